/* storeBuffer_macros.svh */
`ifndef STOREBUFFER_MACROS_SVH
`define STOREBUFFER_MACROS_SVH

// store buffer depth, also works with 2 or 8
`define SB_ENTRIES 4

// backing memory size in words
`define MEM_WORDS 256

`define DATA_W 32

// cycles from the first memory request to its ack
`define MEM_LATENCY 3

`endif

/* storeBufferPkg.sv */
`include "storeBuffer_macros.svh"

package storeBufferPkg;

    typedef logic [$clog2(`MEM_WORDS)-1:0] wordAddr;  // word index into the backing memory

    typedef logic [`DATA_W/8-1:0] byteMask;

    typedef logic [`DATA_W-1:0] dataWord;

    typedef enum logic {
        reqLoad,
        reqStore
    } reqKind;

    // one store buffer slot
    typedef struct packed {
        logic    valid;
        wordAddr addr;
        dataWord data;
        byteMask mask;  // lanes written since the slot was allocated
    } sbEntry;

endpackage

/* memReqIf.sv */
`timescale 1ns/1ps

// request channel from the APB unit into the store buffer
interface sbReqIf;
    import storeBufferPkg::*;

    logic    valid;
    reqKind  kind;
    wordAddr addr;
    dataWord wdata;
    byteMask strb;
    logic    ready;
    dataWord rdata;
    logic    done;  // one cycle pulse, rdata is valid with it on loads

    modport requester (output valid, kind, addr, wdata, strb, input ready, rdata, done);
    modport server (input valid, kind, addr, wdata, strb, output ready, rdata, done);
endinterface

// memory port, req holds with its fields until ack
interface memPortIf;
    import storeBufferPkg::*;

    logic    req;
    logic    write;
    wordAddr addr;
    dataWord wdata;
    byteMask strb;
    logic    ack;
    dataWord rdata;

    modport master (output req, write, addr, wdata, strb, input ack, rdata);
    modport slave (input req, write, addr, wdata, strb, output ack, rdata);
endinterface

/* apbLoadStoreUnit.sv */
`timescale 1ns/1ps
`include "storeBuffer_macros.svh"

module apbLoadStoreUnit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [31:0]             PADDR,
    input  logic [`DATA_W-1:0]      PWDATA,
    input  storeBufferPkg::byteMask PSTRB,
    output logic [`DATA_W-1:0]      PRDATA,
    output logic                    PREADY,
    output logic                    PSLVERR,
    sbReqIf.requester               req
);
    import storeBufferPkg::*;

    localparam int ByteShift = $clog2(`DATA_W / 8);
    localparam logic [31:0] WordLimit = `MEM_WORDS;

    logic        setupPhase;
    logic        accessPhase;
    logic        inRange;
    logic        pending;
    logic [31:0] wordIndex;

    assign setupPhase  = PSEL && !PENABLE;
    assign accessPhase = PSEL && PENABLE;

    // byte address to word index, the low lane bits are ignored
    assign wordIndex = PADDR >> ByteShift;
    assign inRange   = wordIndex < WordLimit;

    // pending blocks a second request while the first one is still in the buffer
    assign req.valid = accessPhase && inRange && !pending;
    assign req.kind  = PWRITE ? reqStore : reqLoad;
    assign req.addr  = wordAddr'(wordIndex);
    assign req.wdata = PWDATA;
    assign req.strb  = PSTRB;

    // bad addresses are answered right here and never reach the buffer
    assign PSLVERR = accessPhase && !inRange;
    assign PREADY  = req.done || PSLVERR;
    assign PRDATA  = req.rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (req.done) begin
            pending <= 1'b0;
        end else if (req.valid && req.ready) begin
            pending <= 1'b1;  // load accepted, done comes later
        end
    end

    // the access phase must come out of a setup phase of the same transfer
    penableNeedsSetup: assert property (
        @(posedge clk) disable iff (reset)
        $rose(PENABLE) |-> PSEL && $past(setupPhase)
    ) else $error("PENABLE rose without a preceding APB setup phase");

endmodule

/* storeBuffer.sv */
`timescale 1ns/1ps
`include "storeBuffer_macros.svh"

module storeBuffer (
    input  logic     clk,
    input  logic     reset,
    sbReqIf.server   req,
    memPortIf.master mem
);
    import storeBufferPkg::*;

    localparam int Entries = `SB_ENTRIES;
    localparam int IdxW    = $clog2(Entries);
    localparam int Lanes   = `DATA_W / 8;

    typedef enum logic [2:0] {
        stIdle,
        stLoadFwd,   // full-mask hit answered in the next cycle
        stLoadWait,  // matching entries still have to drain
        stLoadMem,
        stLoadDone
    } loadState;

    sbEntry             entries [Entries];  // slot 0 is the oldest
    sbEntry             entriesNext [Entries];
    loadState           state;
    wordAddr            loadAddr;
    dataWord            loadData;
    logic [Entries-1:0] validVec;
    logic [Entries-1:0] hitVec;
    logic [Entries-1:0] loadMatchVec;
    logic [IdxW-1:0]    hitIdx;
    logic [IdxW-1:0]    freeIdx;
    logic               hit;
    logic               full;
    logic               loadMatch;
    logic               storeTake;
    logic               loadTake;
    logic               loadOwnsPort;
    logic               drainAck;
    logic               dupFound;

    always_comb begin
        hitIdx  = '0;
        freeIdx = '0;
        for (int i = Entries - 1; i >= 0; i--) begin
            validVec[i]     = entries[i].valid;
            hitVec[i]       = entries[i].valid && entries[i].addr == req.addr;
            loadMatchVec[i] = entries[i].valid && entries[i].addr == loadAddr;
            if (hitVec[i]) hitIdx = IdxW'(i);
            if (!entries[i].valid) freeIdx = IdxW'(i);  // lowest free slot wins
        end
    end

    assign hit          = |hitVec;
    assign full         = &validVec;
    assign loadMatch    = |loadMatchVec;
    assign loadOwnsPort = state == stLoadMem;
    assign storeTake    = req.valid && req.ready && req.kind == reqStore;
    assign loadTake     = req.valid && req.ready && req.kind == reqLoad;
    assign drainAck     = mem.ack && !loadOwnsPort;

    assign req.ready = req.valid && state == stIdle && !(req.kind == reqStore && full && !hit);
    assign req.done  = storeTake || state == stLoadFwd || state == stLoadDone;
    assign req.rdata = loadData;

    // the oldest slot drains whenever the port is not held by a load
    assign mem.req   = loadOwnsPort || entries[0].valid;
    assign mem.write = !loadOwnsPort;
    assign mem.addr  = loadOwnsPort ? loadAddr : entries[0].addr;
    assign mem.wdata = entries[0].data;
    assign mem.strb  = loadOwnsPort ? '0 : entries[0].mask;

    always_comb begin
        entriesNext = entries;
        if (storeTake && hit) begin
            for (int b = 0; b < Lanes; b++) begin
                if (req.strb[b]) entriesNext[hitIdx].data[8*b +: 8] = req.wdata[8*b +: 8];
            end
            entriesNext[hitIdx].mask = entries[hitIdx].mask | req.strb;
        end else if (storeTake) begin
            entriesNext[freeIdx] = '{valid: 1'b1, addr: req.addr,
                                     data: req.wdata, mask: req.strb};
        end
        // a store merging into the draining slot keeps it for another drain
        if (drainAck && !(storeTake && hit && hitIdx == '0)) begin
            for (int i = 0; i < Entries - 1; i++) begin
                entriesNext[i] = entriesNext[i + 1];
            end
            entriesNext[Entries - 1].valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
            for (int i = 0; i < Entries; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= entriesNext;
            case (state)
                stIdle: begin
                    if (loadTake) begin
                        state <= (hit && &entries[hitIdx].mask) ? stLoadFwd : stLoadWait;
                    end
                end
                stLoadFwd: state <= stIdle;
                stLoadWait: begin
                    // the port is free once the current drain is acked or nothing is left
                    if (!loadMatch && (!entries[0].valid || mem.ack)) state <= stLoadMem;
                end
                stLoadMem: begin
                    if (mem.ack) state <= stLoadDone;
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadTake) begin
            loadAddr <= req.addr;
            loadData <= entries[hitIdx].data;  // only used on a full-mask hit
        end else if (loadOwnsPort && mem.ack) begin
            loadData <= mem.rdata;
        end
    end

    always_comb begin
        dupFound = 1'b0;
        for (int i = 0; i < Entries; i++) begin
            for (int j = i + 1; j < Entries; j++) begin
                if (entries[i].valid && entries[j].valid && entries[i].addr == entries[j].addr)
                    dupFound = 1'b1;
            end
        end
    end

    // an accepted store miss has to land in a slot that is really free
    storeMissGetsFreeSlot: assert property (
        @(posedge clk) disable iff (reset)
        storeTake && !hit |-> !entries[freeIdx].valid
    ) else $error("store miss accepted with no free store buffer slot");

    // merging relies on each word living in at most one slot
    noDuplicateEntries: assert property (
        @(posedge clk) disable iff (reset) !dupFound
    ) else $error("two valid store buffer entries share one address");

endmodule

/* backingMemory.sv */
`timescale 1ns/1ps
`include "storeBuffer_macros.svh"

module backingMemory (
    input  logic    clk,
    input  logic    reset,
    memPortIf.slave mem
);
    import storeBufferPkg::*;

    localparam int Words   = `MEM_WORDS;
    localparam int Latency = `MEM_LATENCY;
    localparam int CountW  = $clog2(Latency + 1);
    localparam int Lanes   = `DATA_W / 8;

    dataWord           storage [Words];
    logic [CountW-1:0] waitCount;  // cycles since req was first seen

    assign mem.ack   = mem.req && waitCount == CountW'(Latency);
    assign mem.rdata = storage[mem.addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            waitCount <= '0;
        end else if (mem.ack) begin
            waitCount <= '0;  // a new request may follow right away
        end else if (mem.req) begin
            waitCount <= waitCount + 1'b1;
        end
    end

    // writes land in the ack cycle, only on the strobed lanes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < Words; i++) begin
                storage[i] <= '0;
            end
        end else if (mem.ack && mem.write) begin
            for (int b = 0; b < Lanes; b++) begin
                if (mem.strb[b]) storage[mem.addr][8*b +: 8] <= mem.wdata[8*b +: 8];
            end
        end
    end

    reqHeldUntilAck: assert property (
        @(posedge clk) disable iff (reset)
        mem.req && !mem.ack |=> mem.req && $stable(mem.addr) && $stable(mem.write)
    ) else $error("memory request changed before its ack");

endmodule

/* loadStoreTop.sv */
`timescale 1ns/1ps
`include "storeBuffer_macros.svh"

module loadStoreTop (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [31:0]             PADDR,
    input  logic [`DATA_W-1:0]      PWDATA,
    input  storeBufferPkg::byteMask PSTRB,
    output logic [`DATA_W-1:0]      PRDATA,
    output logic                    PREADY,
    output logic                    PSLVERR
);

    sbReqIf   sbReq ();
    memPortIf memPort ();

    apbLoadStoreUnit u_apbLoadStoreUnit (
        .clk     (clk),
        .reset   (reset),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PSTRB   (PSTRB),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR),
        .req     (sbReq.requester)
    );

    storeBuffer u_storeBuffer (
        .clk   (clk),
        .reset (reset),
        .req   (sbReq.server),
        .mem   (memPort.master)
    );

    backingMemory u_backingMemory (
        .clk   (clk),
        .reset (reset),
        .mem   (memPort.slave)
    );

endmodule

/* storeBufferTb.sv */
`timescale 1ns/1ps
`include "storeBuffer_macros.svh"

module storeBufferTb;
    import storeBufferPkg::*;

    localparam int ResetCycles = 10;

    logic        clk;
    logic        reset;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [31:0] PADDR;
    dataWord     PWDATA;
    byteMask     PSTRB;
    dataWord     PRDATA;
    logic        PREADY;
    logic        PSLVERR;

    // one entry per test line of storeTests.txt
    string       testName [$];
    bit          testStore [$];
    logic [31:0] testAddr [$];
    byteMask     testStrb [$];
    dataWord     testWdata [$];
    dataWord     testRdata [$];
    logic        testErr [$];

    int errorCount = 0;
    int passCount  = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    loadStoreTop u_loadStoreTop (
        .clk     (clk),
        .reset   (reset),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PSTRB   (PSTRB),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("simulation timed out after %0d cycles without finishing the tests",
                     cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    task automatic readTests();
        int          fd;
        int          n;
        string       textLine;
        string       name;
        string       op;
        logic [31:0] addr;
        byteMask     strb;
        dataWord     wdata;
        dataWord     rdata;
        logic        err;
        fd = $fopen("storeTests.txt", "r");
        assert (fd != 0) else begin
            $display("could not open storeTests.txt");
            errorCount++;
        end
        while (fd != 0 && !$feof(fd)) begin
            textLine = "";
            void'($fgets(textLine, fd));
            if (textLine.len() > 1 && textLine.getc(0) != "#") begin
                n = $sscanf(textLine, "%s %s %h %h %h %h %h", name, op, addr, strb, wdata,
                            rdata, err);
                assert (n == 7) else begin
                    $display("malformed line in storeTests.txt: %s", textLine);
                    errorCount++;
                end
                if (n == 7) begin
                    testName.push_back(name);
                    testStore.push_back(op == "store");
                    testAddr.push_back(addr);
                    testStrb.push_back(strb);
                    testWdata.push_back(wdata);
                    testRdata.push_back(rdata);
                    testErr.push_back(err);
                end
            end
        end
        if (fd != 0) $fclose(fd);
    endtask

    // starts 2 ns after an edge and returns 2 ns after the edge that completes the transfer
    task automatic apbTransfer(input bit write, input logic [31:0] addr, input byteMask strb,
                               input dataWord wdata, output dataWord rdata, output logic err);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = write;
        PADDR   = addr;
        PSTRB   = strb;
        PWDATA  = wdata;
        @(posedge clk);
        #2;
        PENABLE = 1'b1;
        @(negedge clk);
        while (!PREADY) @(negedge clk);  // sampled mid cycle where PREADY is settled
        rdata = PRDATA;
        err   = PSLVERR;
        @(posedge clk);
        #2;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic runTest(input int idx);
        dataWord gotData;
        logic    gotErr;
        int      errorsBefore;
        errorsBefore = errorCount;
        apbTransfer(testStore[idx], testAddr[idx], testStrb[idx], testWdata[idx],
                    gotData, gotErr);
        assert (gotErr === testErr[idx]) else begin
            $display("Mismatch %s: expected PSLVERR %0b, actual %0b", testName[idx],
                     testErr[idx], gotErr);
            errorCount++;
        end
        if (!testStore[idx] && !testErr[idx]) begin
            assert (gotData === testRdata[idx]) else begin
                $display("Mismatch %s: expected %h, actual %h", testName[idx],
                         testRdata[idx], gotData);
                errorCount++;
            end
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("%s: pass", testName[idx]);
        end else begin
            $display("%s: FAIL", testName[idx]);
        end
    endtask

    initial begin
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        PSTRB   = '0;
        reset   = 1'b1;
        readTests();
        assert (testName.size() > 0) else begin
            $display("no tests were read from storeTests.txt");
            errorCount++;
        end
        // worst case per test is a load that waits for every entry to drain
        cycleLimit = testName.size() * (`SB_ENTRIES + 2) * (`MEM_LATENCY + 2) + ResetCycles;
        repeat (ResetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < testName.size(); i++) begin
            runTest(i);
        end
        $display("tests run: %0d, passed: %0d, failed: %0d", testName.size(), passCount,
                 testName.size() - passCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* storeTests.txt */
# name op byteAddr strb wdata expectedRdata expectedErr, all hex, rdata checked on good loads only
# a load sees the latest stored byte in each lane, zero where nothing was stored
st_word store 010 f 11223344 00000000 0
ld_fwd load 010 0 00000000 11223344 0
st_half_lo store 020 3 0000beef 00000000 0
st_half_hi store 020 c cafe0000 00000000 0
ld_half load 020 0 00000000 cafebeef 0
st_byte2 store 010 4 00aa0000 00000000 0
ld_byte2 load 010 0 00000000 11aa3344 0
st_fill0 store 100 f 5a5a0100 00000000 0
st_fill1 store 104 f 5a5a0104 00000000 0
st_fill2 store 108 f 5a5a0108 00000000 0
st_fill3 store 10c f 5a5a010c 00000000 0
st_fill4 store 110 f 5a5a0110 00000000 0
st_fill5 store 114 f 5a5a0114 00000000 0
st_fill6 store 118 f 5a5a0118 00000000 0
ld_fill0 load 100 0 00000000 5a5a0100 0
ld_fill1 load 104 0 00000000 5a5a0104 0
ld_fill2 load 108 0 00000000 5a5a0108 0
ld_fill3 load 10c 0 00000000 5a5a010c 0
ld_fill4 load 110 0 00000000 5a5a0110 0
ld_fill5 load 114 0 00000000 5a5a0114 0
ld_fill6 load 118 0 00000000 5a5a0118 0
ld_unwritten load 3fc 0 00000000 00000000 0
st_oob store 400 f deadbeef 00000000 1
ld_oob load 7f0 0 00000000 00000000 1
ld_word0 load 000 0 00000000 00000000 0
st_rep0 store 040 f 01010101 00000000 0
st_rep1 store 040 f 02020202 00000000 0
st_rep2 store 040 1 000000ff 00000000 0
ld_rep load 040 0 00000000 020202ff 0

/* all.f */
+incdir+.
storeBufferPkg.sv
memReqIf.sv
apbLoadStoreUnit.sv
storeBuffer.sv
backingMemory.sv
loadStoreTop.sv
storeBufferTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module storeBufferTb -f all.f
simOutput=$(./obj_dir/VstoreBufferTb)
echo "$simOutput"
grep -q "^No errors$" <<< "$simOutput"
